//--- dv/tb_mem_system.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module tb_mem_system;
	import mem_pkg::*;
	import disp_pkg::*;

	localparam int CLK_NS = 100;
	localparam int SEED = 93420;
	localparam int FB_WORDS = `H_ACTIVE * `V_ACTIVE;
	localparam int LINE_CYCLES = `H_ACTIVE + `H_BLANK;
	localparam int FRAME_CYCLES = LINE_CYCLES * (`V_ACTIVE + `V_BLANK);
	localparam int NUM_FRAMES = 8;
	localparam int HEAVY_FROM = 3;
	localparam int MIN_PASSES = 3;
	localparam int ACK_TIMEOUT = 64;
	localparam int WATCHDOG_NS = (NUM_FRAMES + 3) * FRAME_CYCLES * CLK_NS;

	logic clk10M;
	logic rst;
	logic host_req;
	logic host_wr;
	mem_addr_t host_addr;
	mem_data_t host_wdata;
	logic host_ack;
	rgb888_t pixel;
	logic de, hsync, vsync, underrun;
	logic test_fail, pass_done;

	// Memory contents as the host wrote them, and the copy for the frame on screen
	mem_data_t shadow [FB_WORDS];
	mem_data_t frame_ref [FB_WORDS];

	int pix_idx = 0;
	int de_run = 0;
	int de_lines = 0;
	int hsync_cnt = 0;
	int vsync_cycles = 0;
	int frame_cycles = 0;
	int frames_checked = 0;
	int passes_seen = 0;
	logic de_q = 1'b0;
	logic hsync_q = 1'b0;
	logic vsync_q = 1'b0;
	logic window_open = 1'b0;

	mem_system DUT (
		.clk10M(clk10M),
		.rst(rst),
		.host_req(host_req),
		.host_wr(host_wr),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_ack(host_ack),
		.pixel(pixel),
		.de(de),
		.hsync(hsync),
		.vsync(vsync),
		.underrun(underrun),
		.test_fail(test_fail),
		.pass_done(pass_done)
	);

	initial begin
		clk10M = 1'b0;
		forever #(CLK_NS / 2) clk10M = ~clk10M;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	// Widen each RGB565 channel by refilling its low bits from the top
	function automatic rgb888_t decode_pixel(input mem_data_t raw);
		pixel_word_u w;
		rgb888_t c;
		logic [7:0] r8;
		logic [7:0] g8;
		logic [7:0] b8;
		w.raw = raw;
		r8 = {3'b000, w.rgb.red};
		g8 = {2'b00, w.rgb.green};
		b8 = {3'b000, w.rgb.blue};
		c.red = (r8 << 3) | (r8 >> 2);
		c.green = (g8 << 2) | (g8 >> 4);
		c.blue = (b8 << 3) | (b8 >> 2);
		return c;
	endfunction

	task automatic compare_pixel(input int idx, input rgb888_t got, input rgb888_t exp);
		if (got !== exp)
			abort_run($sformatf("FAILED pixel[%0d] got 0x%h expected 0x%h", idx, got, exp));
	endtask

	task automatic expect_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic verify_count(input string name, input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// Starts just after a rising edge and returns just after the edge that ends the ack cycle
	task automatic host_write(input int offset, input mem_data_t data);
		int waited;
		waited = 0;
		host_req <= 1'b1;
		host_wr <= 1'b1;
		host_addr <= mem_addr_t'(`FB_BASE + offset);
		host_wdata <= data;
		@(negedge clk10M);
		while (!host_ack) begin
			waited++;
			if (waited > ACK_TIMEOUT)
				abort_run("host write was never acknowledged");
			@(negedge clk10M);
		end
		@(posedge clk10M);
		shadow[offset] = data;
	endtask

	task automatic host_release();
		host_req <= 1'b0;
		host_wr <= 1'b0;
	endtask

	// Frames are delimited by the rising edge of vsync
	always @(negedge clk10M) begin
		if (!rst) begin
			expect_flag("test_fail", test_fail, 1'b0);
			expect_flag("underrun", underrun, 1'b0);
			if (host_ack)
				expect_flag("host_req", host_req, 1'b1);
			if (hsync && hsync_q)
				abort_run("hsync stayed high for more than one cycle");
			if (vsync && !vsync_q) begin
				if (window_open) begin
					verify_count("frame cycles", frame_cycles, FRAME_CYCLES);
					verify_count("de lines per frame", de_lines, `V_ACTIVE);
					verify_count("hsync pulses per frame", hsync_cnt, `V_ACTIVE + `V_BLANK);
					verify_count("vsync cycles per frame", vsync_cycles, LINE_CYCLES);
					verify_count("pixels per frame", pix_idx, FB_WORDS);
					frames_checked++;
				end
				window_open = 1'b1;
				frame_cycles = 0;
				de_lines = 0;
				hsync_cnt = 0;
				vsync_cycles = 0;
				pix_idx = 0;
			end
			frame_cycles++;
			if (hsync)
				hsync_cnt++;
			if (vsync)
				vsync_cycles++;
			if (de) begin
				if (!window_open)
					abort_run("de went high before the first vertical blank");
				if (pix_idx >= FB_WORDS)
					abort_run("more de cycles in a frame than framebuffer words");
				if (pix_idx == 0)
					frame_ref = shadow;
				compare_pixel(pix_idx, pixel, decode_pixel(frame_ref[pix_idx]));
				pix_idx++;
				de_run++;
			end else if (de_q) begin
				verify_count("de cycles per line", de_run, `H_ACTIVE);
				de_lines++;
				de_run = 0;
			end
			if (pass_done)
				passes_seen++;
			de_q = de;
			hsync_q = hsync;
			vsync_q = vsync;
		end
	end

	initial begin
		int i;
		int f;
		void'($urandom(SEED));
		rst = 1'b1;
		host_req = 1'b0;
		host_wr = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		repeat (5) @(posedge clk10M);
		rst <= 1'b0;
		@(posedge clk10M);

		// Fill the framebuffer while the first frame is still blank
		for (i = 0; i < FB_WORDS; i++)
			host_write(i, mem_data_t'($urandom));
		host_release();
		if (window_open)
			abort_run("framebuffer fill ran into the first vertical blank");
		wait (window_open);

		for (f = 1; f <= NUM_FRAMES; f++) begin
			// Words of the last visible line are already queued
			repeat (`V_ACTIVE) @(posedge de);
			@(posedge clk10M);
			if (f < NUM_FRAMES) begin
				if (f < HEAVY_FROM) begin
					for (i = 0; i < 4; i++)
						host_write(`H_ACTIVE + int'($urandom % (FB_WORDS - `H_ACTIVE)),
							mem_data_t'($urandom));
				end else begin
					for (i = `H_ACTIVE; i < FB_WORDS; i++)
						host_write(i, mem_data_t'($urandom));
				end
				host_release();
			end
			wait (frames_checked == f);
		end
		repeat (2) @(posedge clk10M);

		if (passes_seen < MIN_PASSES) begin
			abort_run($sformatf("memory test finished only %0d passes", passes_seen));
		end else begin
			$display("sim passed");
			$finish;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run("watchdog expired before all frames were checked");
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/mem_pkg.sv
source/disp_pkg.sv
source/mem_arbiter.sv
source/burst_mem.sv
source/mem_test.sv
source/disp_scan.sv
source/mem_system.sv
dv/tb_mem_system.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mem_system -f project.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

//--- source/burst_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module burst_mem (
	input logic clk10M,
	input logic rst,
	input logic mreq,
	input logic mwr,
	input mem_pkg::mem_addr_t maddr,
	input mem_pkg::mem_data_t mwdata,
	input mem_pkg::mem_id_t mid,

	output logic mack,
	output logic rvalid,
	output mem_pkg::mem_data_t rdata,
	output mem_pkg::mem_id_t rid
);
	import mem_pkg::*;

	localparam int CNT_W = $clog2(`MEM_BURST) + 1;
	localparam logic [CNT_W-1:0] CNT_END = CNT_W'(`MEM_BURST);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT,
		S_BURST
	} state_t;

	state_t state;
	mem_data_t mem [2**`MEM_AN];
	mem_addr_t base;
	mem_addr_t rd_addr;
	logic [CNT_W-1:0] cnt;

	// Accept only when nothing is in flight
	assign mack = (state == S_IDLE) & mreq;
	assign rd_addr = base + mem_addr_t'(cnt);

	always_ff @(posedge clk10M) begin
		if (mack && mwr)
			mem[maddr] <= mwdata;
		rdata <= mem[rd_addr];
	end

	always_ff @(posedge clk10M) begin
		if (mack && !mwr) begin
			base <= maddr;
			rid <= mid;
		end
	end

	always_ff @(posedge clk10M) begin
		if (rst) begin
			state <= S_IDLE;
			rvalid <= 1'b0;
			cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					rvalid <= 1'b0;
					if (mack && !mwr) begin
						cnt <= '0;
						state <= S_WAIT;
					end
				end
				S_WAIT: begin
					// First word leaves the array now
					rvalid <= 1'b1;
					cnt <= CNT_W'(1);
					state <= S_BURST;
				end
				S_BURST: begin
					if (cnt == CNT_END) begin
						rvalid <= 1'b0;
						state <= S_IDLE;
					end else begin
						rvalid <= 1'b1;
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	no_ack_in_burst: assert property (@(posedge clk10M) disable iff (rst)
		rvalid |-> !mack);

	read_latency: assert property (@(posedge clk10M) disable iff (rst)
		mack && !mwr |-> ##2 rvalid [*`MEM_BURST] ##1 !rvalid);

endmodule

`default_nettype wire

//--- source/disp_pkg.sv
`default_nettype none

package disp_pkg;

	// RGB565 as stored in the framebuffer
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	// Same word, seen raw by the bus or as colour by the scanner
	typedef union packed {
		mem_pkg::mem_data_t raw;
		rgb565_t rgb;
	} pixel_word_u;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb888_t;

endpackage

`default_nettype wire

//--- source/disp_scan.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module disp_scan (
	input logic clk10M,
	input logic rst,
	input logic ack,
	input logic rvalid,
	input mem_pkg::mem_data_t rdata,
	input mem_pkg::mem_id_t rid,

	output logic req,
	output mem_pkg::mem_addr_t addr,

	output disp_pkg::rgb888_t pixel,
	output logic de,
	output logic hsync,
	output logic vsync,
	output logic underrun
);
	import mem_pkg::*;
	import disp_pkg::*;

	localparam int HW = $clog2(`H_ACTIVE + `H_BLANK);
	localparam int VW = $clog2(`V_ACTIVE + `V_BLANK);
	localparam int DEPTH = 2 * `MEM_BURST;
	localparam int PTR_W = $clog2(DEPTH);
	localparam logic [HW-1:0] H_ACT = HW'(`H_ACTIVE);
	localparam logic [HW-1:0] H_LAST = HW'(`H_ACTIVE + `H_BLANK - 1);
	localparam logic [VW-1:0] V_ACT = VW'(`V_ACTIVE);
	localparam logic [VW-1:0] V_LAST = VW'(`V_ACTIVE + `V_BLANK - 1);
	localparam logic [PTR_W:0] BURST_N = (PTR_W + 1)'(`MEM_BURST);
	localparam logic [PTR_W+1:0] ROOM = (PTR_W + 2)'(DEPTH - `MEM_BURST);
	localparam mem_addr_t FB_FIRST = mem_addr_t'(`FB_BASE);
	localparam mem_addr_t FB_LAST = mem_addr_t'(`FB_BASE + `H_ACTIVE * `V_ACTIVE - `MEM_BURST);

	logic [HW-1:0] hcnt;
	logic [VW-1:0] vcnt;
	logic scan_en;
	logic active, blank, fetch_en;
	mem_data_t queue [DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [PTR_W:0] count, inflight;
	logic [PTR_W+1:0] level;
	logic push, pop;

	// Widen each channel by repeating its top bits
	function automatic rgb888_t expand(mem_data_t raw);
		pixel_word_u w;
		rgb888_t c;
		w.raw = raw;
		c.red = {w.rgb.red, w.rgb.red[4:2]};
		c.green = {w.rgb.green, w.rgb.green[5:4]};
		c.blue = {w.rgb.blue, w.rgb.blue[4:2]};
		return c;
	endfunction

	assign active = scan_en && (hcnt < H_ACT) && (vcnt < V_ACT);
	assign blank = (hcnt >= H_ACT) || (vcnt >= V_ACT);
	// Before the first visible frame only the vertical blank fetches
	assign fetch_en = blank && (scan_en || (vcnt >= V_ACT));

	assign push = rvalid && (rid == ID_DISP);
	assign pop = active && (count != '0);
	assign level = {1'b0, count} + {1'b0, inflight};

	always_ff @(posedge clk10M) begin
		if (push)
			queue[wr_ptr] <= rdata;
		pixel <= pop ? expand(queue[rd_ptr]) : '0;
	end

	always_ff @(posedge clk10M) begin
		if (rst) begin
			hcnt <= '0;
			vcnt <= '0;
			scan_en <= 1'b0;
			de <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			underrun <= 1'b0;
		end else begin
			if (hcnt == H_LAST) begin
				hcnt <= '0;
				if (vcnt == V_LAST) begin
					vcnt <= '0;
					scan_en <= 1'b1;
				end else begin
					vcnt <= vcnt + 1'b1;
				end
			end else begin
				hcnt <= hcnt + 1'b1;
			end
			de <= active;
			hsync <= (hcnt == '0);
			vsync <= (vcnt == V_ACT);
			if (active && count == '0)
				underrun <= 1'b1;
		end
	end

	// Burst fetch and line queue bookkeeping
	always_ff @(posedge clk10M) begin
		if (rst) begin
			req <= 1'b0;
			addr <= FB_FIRST;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			inflight <= '0;
		end else begin
			if (req) begin
				if (ack) begin
					req <= 1'b0;
					addr <= (addr == FB_LAST) ? FB_FIRST : addr + mem_addr_t'(`MEM_BURST);
				end
			end else if (fetch_en && level <= ROOM) begin
				req <= 1'b1;
			end
			inflight <= inflight + (ack ? BURST_N : '0) - {{PTR_W{1'b0}}, push};
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	no_overflow: assert property (@(posedge clk10M) disable iff (rst)
		push |-> (count < DEPTH) || pop);

endmodule

`default_nettype wire

//--- source/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input logic clk10M,
	input logic rst,

	input logic host_req,
	input logic host_wr,
	input mem_pkg::mem_addr_t host_addr,
	input mem_pkg::mem_data_t host_wdata,

	input logic disp_req,
	input mem_pkg::mem_addr_t disp_addr,

	input logic test_req,
	input logic test_wr,
	input mem_pkg::mem_addr_t test_addr,
	input mem_pkg::mem_data_t test_wdata,

	input logic mack,

	output logic host_ack,
	output logic disp_ack,
	output logic test_ack,

	output logic mreq,
	output logic mwr,
	output mem_pkg::mem_addr_t maddr,
	output mem_pkg::mem_data_t mwdata,
	output mem_pkg::mem_id_t mid
);
	import mem_pkg::*;

	logic host_win, disp_win, test_win;

	// Host wins over display, display over test
	assign host_win = host_req;
	assign disp_win = disp_req & ~host_req;
	assign test_win = test_req & ~host_req & ~disp_req;

	assign mreq = host_req | disp_req | test_req;

	always_comb begin
		mwr = test_wr;
		maddr = test_addr;
		mwdata = test_wdata;
		mid = ID_TEST;
		if (host_win) begin
			mwr = host_wr;
			maddr = host_addr;
			mwdata = host_wdata;
			mid = ID_HOST;
		end else if (disp_win) begin
			// Display only reads
			mwr = 1'b0;
			maddr = disp_addr;
			mwdata = '0;
			mid = ID_DISP;
		end
	end

	assign host_ack = mack & host_win;
	assign disp_ack = mack & disp_win;
	assign test_ack = mack & test_win;

	property req_held(r, a);
		@(posedge clk10M) disable iff (rst) r && !a |=> r;
	endproperty

	ack_needs_req: assert property (@(posedge clk10M) disable iff (rst)
		mack |-> mreq);

	host_held: assert property (req_held(host_req, host_ack));
	disp_held: assert property (req_held(disp_req, disp_ack));
	test_held: assert property (req_held(test_req, test_ack));

endmodule

`default_nettype wire

//--- source/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Memory geometry
`define MEM_AN 12
`define MEM_DN 16
`define MEM_BURST 4

// Word address map, framebuffer at the bottom
`define FB_BASE 0
`define TEST_BASE 256
`define TEST_LEN 32

// Display timing, cycles per line and lines per frame
`define H_ACTIVE 8
`define H_BLANK 24
`define V_ACTIVE 4
`define V_BLANK 2

`endif

//--- source/mem_pkg.sv
`default_nettype none

`include "mem_config.svh"

package mem_pkg;

	typedef logic [`MEM_AN-1:0] mem_addr_t;
	typedef logic [`MEM_DN-1:0] mem_data_t;
	typedef logic [1:0] mem_id_t;

	// Client ids on the shared bus
	localparam mem_id_t ID_HOST = 2'd0;
	localparam mem_id_t ID_DISP = 2'd1;
	localparam mem_id_t ID_TEST = 2'd2;

endpackage

`default_nettype wire

//--- source/mem_system.sv
`timescale 1ns/1ps
`default_nettype none

module mem_system (
	input logic clk10M,
	input logic rst,

	input logic host_req,
	input logic host_wr,
	input mem_pkg::mem_addr_t host_addr,
	input mem_pkg::mem_data_t host_wdata,
	output logic host_ack,

	output disp_pkg::rgb888_t pixel,
	output logic de,
	output logic hsync,
	output logic vsync,
	output logic underrun,

	output logic test_fail,
	output logic pass_done
);
	import mem_pkg::*;

	logic disp_req, disp_ack;
	mem_addr_t disp_addr;

	logic test_req, test_wr, test_ack;
	mem_addr_t test_addr;
	mem_data_t test_wdata;

	logic mreq, mwr, mack;
	mem_addr_t maddr;
	mem_data_t mwdata;
	mem_id_t mid;

	// Read return, broadcast to every client
	logic rvalid;
	mem_data_t rdata;
	mem_id_t rid;

	mem_arbiter arb0 (
		.clk10M(clk10M),
		.rst(rst),
		.host_req(host_req),
		.host_wr(host_wr),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.disp_req(disp_req),
		.disp_addr(disp_addr),
		.test_req(test_req),
		.test_wr(test_wr),
		.test_addr(test_addr),
		.test_wdata(test_wdata),
		.mack(mack),
		.host_ack(host_ack),
		.disp_ack(disp_ack),
		.test_ack(test_ack),
		.mreq(mreq),
		.mwr(mwr),
		.maddr(maddr),
		.mwdata(mwdata),
		.mid(mid)
	);

	burst_mem mem0 (
		.clk10M(clk10M),
		.rst(rst),
		.mreq(mreq),
		.mwr(mwr),
		.maddr(maddr),
		.mwdata(mwdata),
		.mid(mid),
		.mack(mack),
		.rvalid(rvalid),
		.rdata(rdata),
		.rid(rid)
	);

	mem_test test0 (
		.clk10M(clk10M),
		.rst(rst),
		.ack(test_ack),
		.rvalid(rvalid),
		.rdata(rdata),
		.rid(rid),
		.req(test_req),
		.wr(test_wr),
		.addr(test_addr),
		.wdata(test_wdata),
		.test_fail(test_fail),
		.pass_done(pass_done)
	);

	disp_scan disp0 (
		.clk10M(clk10M),
		.rst(rst),
		.ack(disp_ack),
		.rvalid(rvalid),
		.rdata(rdata),
		.rid(rid),
		.req(disp_req),
		.addr(disp_addr),
		.pixel(pixel),
		.de(de),
		.hsync(hsync),
		.vsync(vsync),
		.underrun(underrun)
	);

endmodule

`default_nettype wire

//--- source/mem_test.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_test (
	input logic clk10M,
	input logic rst,
	input logic ack,
	input logic rvalid,
	input mem_pkg::mem_data_t rdata,
	input mem_pkg::mem_id_t rid,

	output logic req,
	output logic wr,
	output mem_pkg::mem_addr_t addr,
	output mem_pkg::mem_data_t wdata,
	output logic test_fail,
	output logic pass_done
);
	import mem_pkg::*;

	localparam int IDX_W = $clog2(`TEST_LEN);
	localparam int BW = $clog2(`MEM_BURST);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`TEST_LEN - 1);
	localparam mem_addr_t BASE = mem_addr_t'(`TEST_BASE);

	typedef enum logic [1:0] {
		S_WRITE,
		S_RD_REQ,
		S_RD_WAIT
	} state_t;

	state_t state;
	logic [IDX_W-1:0] idx;
	logic [3:0] pass_cnt;
	logic rx;
	mem_data_t expected;

	// Address with the pass number folded into the low bits
	function automatic mem_data_t pattern(mem_addr_t a, logic [3:0] p);
		return mem_data_t'(a) ^ mem_data_t'(p);
	endfunction

	assign rx = rvalid && (rid == ID_TEST);
	assign expected = pattern(BASE + mem_addr_t'(idx), pass_cnt);

	always_ff @(posedge clk10M) begin
		if (rst) begin
			state <= S_WRITE;
			req <= 1'b0;
			wr <= 1'b0;
			idx <= '0;
			pass_cnt <= '0;
			test_fail <= 1'b0;
			pass_done <= 1'b0;
		end else begin
			pass_done <= 1'b0;
			case (state)
				S_WRITE: begin
					if (!req) begin
						req <= 1'b1;
						wr <= 1'b1;
						addr <= BASE;
						wdata <= pattern(BASE, pass_cnt);
					end else if (ack) begin
						if (idx == IDX_LAST) begin
							// Switch to read-back, request stays up
							wr <= 1'b0;
							addr <= BASE;
							idx <= '0;
							state <= S_RD_REQ;
						end else begin
							idx <= idx + 1'b1;
							addr <= addr + 1'b1;
							wdata <= pattern(addr + 1'b1, pass_cnt);
						end
					end
				end
				S_RD_REQ: begin
					if (ack) begin
						req <= 1'b0;
						state <= S_RD_WAIT;
					end
				end
				S_RD_WAIT: begin
					if (rx) begin
						if (rdata != expected)
							test_fail <= 1'b1;
						idx <= idx + 1'b1;
						if (&idx[BW-1:0]) begin
							if (idx == IDX_LAST) begin
								pass_done <= 1'b1;
								pass_cnt <= pass_cnt + 1'b1;
								idx <= '0;
								state <= S_WRITE;
							end else begin
								req <= 1'b1;
								addr <= addr + mem_addr_t'(`MEM_BURST);
								state <= S_RD_REQ;
							end
						end
					end
				end
				default: state <= S_WRITE;
			endcase
		end
	end

endmodule

`default_nettype wire
